// File: hdl/rv_defs.svh
// RV64 widths and the three machine CSRs; no other CSR address exists in this design
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath and pc width
`define XLEN 64
`define INST_W 32

// register index widths
`define GPR_AW 5
`define CSR_AW 12

// machine-mode CSR addresses
`define CSR_MTVEC 12'h305
`define CSR_MEPC 12'h341
`define CSR_MCAUSE 12'h342

// environment call from M-mode
`define CAUSE_ECALL_M 11

// ebreak passes its argument in a0
`define EBREAK_ARG_REG 10

`endif

// File: hdl/rv_isa_pkg.sv
// encodings for the decoded RV64I and Zicsr subset only; fence and compressed forms are absent
`default_nettype none

package rv_isa_pkg;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_IMM    = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_IMM_W  = 7'b0011011,
    OPC_OP_W   = 7'b0111011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGE  = 3'b101,
    F3_BLTU = 3'b110,
    F3_BGEU = 3'b111
  } br_f3_e;

  // bit 2 is zero-extend for loads
  typedef enum logic [2:0] {
    F3_B  = 3'b000,
    F3_H  = 3'b001,
    F3_W  = 3'b010,
    F3_D  = 3'b011,
    F3_BU = 3'b100,
    F3_HU = 3'b101,
    F3_WU = 3'b110
  } ld_st_f3_e;

  typedef enum logic [2:0] {
    F3_PRIV  = 3'b000, // ecall, ebreak, mret
    F3_CSRRW = 3'b001,
    F3_CSRRS = 3'b010,
    F3_CSRRC = 3'b011
  } csr_f3_e;

  // inst[31:20] under F3_PRIV
  typedef enum logic [11:0] {
    SYS_ECALL  = 12'h000,
    SYS_EBREAK = 12'h001,
    SYS_MRET   = 12'h302
  } sys_imm_e;

endpackage

`default_nettype wire

// File: hdl/rv_ctrl_pkg.sv
// control encodings from decode to execute and the branch unit; execute must agree on alu_op_e
`default_nettype none

package rv_ctrl_pkg;

  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_COPY // pass src2 through, for lui
  } alu_op_e;

  typedef enum logic {SRC1_REG, SRC1_PC} src1_sel_e;

  typedef enum logic [1:0] {SRC2_REG, SRC2_IMM, SRC2_FOUR} src2_sel_e;

  // same coding as the load/store funct3
  typedef enum logic [2:0] {
    MEM_B, MEM_H, MEM_W, MEM_D, MEM_BU, MEM_HU, MEM_WU
  } mem_op_e;

  // low two bits of the csr funct3
  typedef enum logic [1:0] {CSR_NONE, CSR_W, CSR_S, CSR_C} csr_op_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
  } br_func_e;

endpackage

`default_nettype wire

// File: hdl/inst_decoder.sv
// combinational; any encoding outside the subset comes out illegal with every enable and source use low
`default_nettype none
`include "rv_defs.svh"

module inst_decoder import rv_isa_pkg::*, rv_ctrl_pkg::*; (
  input  logic [`INST_W-1:0] i_inst,
  output logic [`GPR_AW-1:0] o_rs1,
  output logic [`GPR_AW-1:0] o_rs2,
  output logic [`GPR_AW-1:0] o_rd,
  output logic               o_rs1_used,
  output logic               o_rs2_used,
  output logic [`XLEN-1:0]   o_imm,
  output logic [`CSR_AW-1:0] o_csr,
  output alu_op_e            o_alu_op,
  output src1_sel_e          o_src1_sel,
  output src2_sel_e          o_src2_sel,
  output logic               o_word_op,
  output br_func_e           o_br_func,
  output logic               o_gpr_wen,
  output logic               o_csr_wen,
  output logic               o_mem_ren,
  output logic               o_mem_wen,
  output mem_op_e            o_mem_op,
  output csr_op_e            o_csr_op,
  output logic               o_csr_to_gpr,
  output logic               o_is_csr,
  output logic               o_ecall,
  output logic               o_ebreak,
  output logic               o_mret,
  output logic               o_illegal
);

  logic [6:0]       opc, f7, sh_hi;
  logic [2:0]       f3;
  logic [`XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic             word, bad;

  assign opc  = i_inst[6:0];
  assign f3   = i_inst[14:12];
  assign f7   = i_inst[31:25];
  assign word = (opc == OPC_IMM_W) || (opc == OPC_OP_W);
  // rv64 shamt is 6 bits, so bit 25 is not part of funct7 for OP-IMM
  assign sh_hi = word ? f7 : {f7[6:1], 1'b0};

  assign imm_i = {{(`XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(`XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  function automatic alu_op_e alu_sel(input logic [2:0] fn, input logic alt);
    case (fn)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    o_rs1        = i_inst[19:15];
    o_rs2        = i_inst[24:20];
    o_rd         = i_inst[11:7];
    o_rs1_used   = 1'b0;
    o_rs2_used   = 1'b0;
    o_imm        = '0;
    o_csr        = '0;
    o_alu_op     = ALU_ADD;
    o_src1_sel   = SRC1_REG;
    o_src2_sel   = SRC2_REG;
    o_word_op    = word;
    o_br_func    = BR_NONE;
    o_gpr_wen    = 1'b0;
    o_csr_wen    = 1'b0;
    o_mem_ren    = 1'b0;
    o_mem_wen    = 1'b0;
    o_mem_op     = mem_op_e'(f3);
    o_csr_op     = CSR_NONE;
    o_csr_to_gpr = 1'b0;
    o_is_csr     = 1'b0;
    o_ecall      = 1'b0;
    o_ebreak     = 1'b0;
    o_mret       = 1'b0;
    bad          = 1'b0;
    case (opc)
      OPC_LUI, OPC_AUIPC: begin
        o_imm      = imm_u;
        o_src1_sel = (opc == OPC_AUIPC) ? SRC1_PC : SRC1_REG;
        o_src2_sel = SRC2_IMM;
        o_alu_op   = (opc == OPC_AUIPC) ? ALU_ADD : ALU_COPY;
        o_gpr_wen  = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin // link value is pc + 4
        o_imm      = (opc == OPC_JAL) ? imm_j : imm_i;
        o_rs1_used = (opc == OPC_JALR);
        o_src1_sel = SRC1_PC;
        o_src2_sel = SRC2_FOUR;
        o_gpr_wen  = 1'b1;
        o_br_func  = (opc == OPC_JAL) ? BR_JAL : BR_JALR;
        bad        = (opc == OPC_JALR) && (f3 != 3'b000);
      end
      OPC_BRANCH: begin
        o_imm      = imm_b;
        o_rs1_used = 1'b1;
        o_rs2_used = 1'b1;
        case (f3)
          F3_BEQ:  o_br_func = BR_EQ;
          F3_BNE:  o_br_func = BR_NE;
          F3_BLT:  o_br_func = BR_LT;
          F3_BGE:  o_br_func = BR_GE;
          F3_BLTU: o_br_func = BR_LTU;
          F3_BGEU: o_br_func = BR_GEU;
          default: bad = 1'b1;
        endcase
      end
      OPC_LOAD, OPC_STORE: begin
        o_rs1_used = 1'b1;
        o_src2_sel = SRC2_IMM;
        if (opc == OPC_LOAD) begin
          o_imm     = imm_i;
          o_mem_ren = 1'b1;
          o_gpr_wen = 1'b1;
          bad       = f3 > F3_WU;
        end else begin
          o_imm      = imm_s;
          o_rs2_used = 1'b1;
          o_mem_wen  = 1'b1;
          bad        = f3 > F3_D; // no unsigned stores
        end
      end
      OPC_IMM, OPC_IMM_W: begin
        o_imm      = imm_i;
        o_rs1_used = 1'b1;
        o_src2_sel = SRC2_IMM;
        o_gpr_wen  = 1'b1;
        o_alu_op   = alu_sel(f3, (f3 == 3'b101) && f7[5]);
        if (f3 == 3'b001)
          bad = sh_hi != 7'b0;
        else if (f3 == 3'b101)
          bad = (sh_hi != 7'b0) && (sh_hi != 7'b0100000);
        else
          bad = word && (f3 != 3'b000);
      end
      OPC_OP, OPC_OP_W: begin
        o_rs1_used = 1'b1;
        o_rs2_used = 1'b1;
        o_gpr_wen  = 1'b1;
        o_alu_op   = alu_sel(f3, f7[5]);
        bad = !((f7 == 7'b0) || ((f7 == 7'b0100000) && (f3 == 3'b000 || f3 == 3'b101)));
        if (word && !(f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101))
          bad = 1'b1;
      end
      OPC_SYSTEM: begin
        case (f3)
          F3_PRIV: begin
            if (o_rd != '0 || o_rs1 != '0) begin
              bad = 1'b1;
            end else begin
              case (i_inst[31:20])
                SYS_ECALL:  o_ecall = 1'b1;
                SYS_MRET:   o_mret = 1'b1;
                SYS_EBREAK: begin
                  o_ebreak   = 1'b1;
                  o_rs1      = `GPR_AW'(`EBREAK_ARG_REG);
                  o_rs1_used = 1'b1;
                end
                default:    bad = 1'b1;
              endcase
            end
          end
          F3_CSRRW, F3_CSRRS, F3_CSRRC: begin
            o_is_csr     = 1'b1;
            o_csr        = i_inst[31:20];
            o_rs1_used   = 1'b1;
            o_csr_op     = csr_op_e'(f3[1:0]);
            // set/clear with x0 only reads
            o_csr_wen    = (f3 == F3_CSRRW) || (o_rs1 != '0);
            o_csr_to_gpr = 1'b1;
            o_gpr_wen    = 1'b1;
          end
          default: bad = 1'b1;
        endcase
      end
      default: bad = 1'b1;
    endcase

    if (bad) begin
      o_rs1_used   = 1'b0;
      o_rs2_used   = 1'b0;
      o_br_func    = BR_NONE;
      o_gpr_wen    = 1'b0;
      o_csr_wen    = 1'b0;
      o_mem_ren    = 1'b0;
      o_mem_wen    = 1'b0;
      o_csr_to_gpr = 1'b0;
      o_is_csr     = 1'b0;
      o_ecall      = 1'b0;
      o_ebreak     = 1'b0;
      o_mret       = 1'b0;
    end
    if (o_rd == '0)
      o_gpr_wen = 1'b0;
    o_illegal = bad;
  end

endmodule

`default_nettype wire

// File: hdl/gpr_file.sv
// no reset so contents are undefined until written; a read in the write cycle sees the old value
`default_nettype none
`include "rv_defs.svh"

module gpr_file (
  input  logic               i_clk,
  // read ports
  input  logic [`GPR_AW-1:0] i_raddr1,
  input  logic [`GPR_AW-1:0] i_raddr2,
  output logic [`XLEN-1:0]   o_rdata1,
  output logic [`XLEN-1:0]   o_rdata2,
  // write port
  input  logic               i_wen,
  input  logic [`GPR_AW-1:0] i_waddr,
  input  logic [`XLEN-1:0]   i_wdata
);

  // x0 has no storage
  logic [`XLEN-1:0] regs [1:(1 << `GPR_AW)-1];

  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0)
      regs[i_waddr] <= i_wdata;
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

// File: hdl/csr_file.sv
// machine mode with mtvec, mepc and mcause only; other addresses read zero and drop writes
`default_nettype none
`include "rv_defs.svh"

module csr_file (
  input  logic               i_clk,
  input  logic               i_rst_n,
  // read port
  input  logic [`CSR_AW-1:0] i_raddr,
  output logic [`XLEN-1:0]   o_rdata,
  // write port from writeback
  input  logic               i_wen,
  input  logic [`CSR_AW-1:0] i_waddr,
  input  logic [`XLEN-1:0]   i_wdata,
  // ecall trap
  input  logic               i_trap,
  input  logic [`XLEN-1:0]   i_trap_pc,
  output logic [`XLEN-1:0]   o_mtvec,
  output logic [`XLEN-1:0]   o_mepc
);

  logic [`XLEN-1:0] mtvec, mepc, mcause;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mtvec  <= '0;
      mepc   <= '0;
      mcause <= '0;
    end else begin
      if (i_wen) begin
        case (i_waddr)
          `CSR_MTVEC:  mtvec <= i_wdata;
          `CSR_MEPC:   mepc <= i_wdata;
          `CSR_MCAUSE: mcause <= i_wdata;
          default:     ;
        endcase
      end
      // trap wins over a same-cycle write
      if (i_trap) begin
        mepc   <= i_trap_pc;
        mcause <= `XLEN'(`CAUSE_ECALL_M);
      end
    end
  end

  always_comb begin
    case (i_raddr)
      `CSR_MTVEC:  o_rdata = mtvec;
      `CSR_MEPC:   o_rdata = mepc;
      `CSR_MCAUSE: o_rdata = mcause;
      default:     o_rdata = '0;
    endcase
  end

  assign o_mtvec = mtvec;
  assign o_mepc  = mepc;

endmodule

`default_nettype wire

// File: hdl/branch_unit.sv
// ecall and mret override the branch function; targets are not checked for alignment
`default_nettype none
`include "rv_defs.svh"

module branch_unit import rv_ctrl_pkg::*; (
  input  br_func_e         i_br_func,
  input  logic [`XLEN-1:0] i_rs1_data,
  input  logic [`XLEN-1:0] i_rs2_data,
  input  logic [`XLEN-1:0] i_pc,
  input  logic [`XLEN-1:0] i_imm,
  input  logic             i_ecall,
  input  logic             i_mret,
  input  logic [`XLEN-1:0] i_mtvec,
  input  logic [`XLEN-1:0] i_mepc,
  output logic             o_taken,
  output logic [`XLEN-1:0] o_target
);

  logic             eq, lt, ltu;
  logic [`XLEN-1:0] jalr_sum;

  assign eq       = i_rs1_data == i_rs2_data;
  assign lt       = $signed(i_rs1_data) < $signed(i_rs2_data);
  assign ltu      = i_rs1_data < i_rs2_data;
  assign jalr_sum = i_rs1_data + i_imm;

  always_comb begin
    o_taken  = 1'b0;
    o_target = i_pc + i_imm; // branches and jal
    if (i_ecall) begin
      o_taken  = 1'b1;
      o_target = i_mtvec;
    end else if (i_mret) begin
      o_taken  = 1'b1;
      o_target = i_mepc;
    end else begin
      case (i_br_func)
        BR_EQ:   o_taken = eq;
        BR_NE:   o_taken = !eq;
        BR_LT:   o_taken = lt;
        BR_GE:   o_taken = !lt;
        BR_LTU:  o_taken = ltu;
        BR_GEU:  o_taken = !ltu;
        BR_JAL:  o_taken = 1'b1;
        BR_JALR: begin
          o_taken  = 1'b1;
          o_target = {jalr_sum[`XLEN-1:1], 1'b0};
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/id_stage.sv
// no forwarding so any es/ms/ws destination match stalls; the trap pc is the decode pc
`default_nettype none
`include "rv_defs.svh"

module id_stage import rv_ctrl_pkg::*; (
  input  logic               i_clk,
  input  logic               i_rst_n,
  // fetch side
  input  logic               i_fs_valid,
  input  logic [`INST_W-1:0] i_fs_inst,
  input  logic [`XLEN-1:0]   i_fs_pc,
  output logic               o_ds_allowin,
  // execute side
  input  logic               i_es_allowin,
  output logic               o_ds_to_es_valid,
  output logic [`XLEN-1:0]   o_es_rs1_data,
  output logic [`XLEN-1:0]   o_es_rs2_data,
  output logic [`XLEN-1:0]   o_es_csr_data,
  output logic [`XLEN-1:0]   o_es_imm,
  output logic [`XLEN-1:0]   o_es_pc,
  output alu_op_e            o_es_alu_op,
  output src1_sel_e          o_es_src1_sel,
  output src2_sel_e          o_es_src2_sel,
  output logic               o_es_word_op,
  output logic [`GPR_AW-1:0] o_es_rd,
  output logic [`CSR_AW-1:0] o_es_csr_addr,
  output logic               o_es_gpr_wen,
  output logic               o_es_csr_wen,
  output logic               o_es_mem_ren,
  output logic               o_es_mem_wen,
  output mem_op_e            o_es_mem_op,
  output csr_op_e            o_es_csr_op,
  output logic               o_es_csr_to_gpr,
  output logic               o_es_ebreak,
  output logic               o_es_illegal,
  // redirect to fetch
  output logic               o_br_taken,
  output logic [`XLEN-1:0]   o_br_target,
  // destinations in flight, 0 is none
  input  logic [`GPR_AW-1:0] i_es_rd,
  input  logic [`GPR_AW-1:0] i_ms_rd,
  input  logic [`GPR_AW-1:0] i_ws_rd,
  input  logic [`CSR_AW-1:0] i_es_csr,
  input  logic [`CSR_AW-1:0] i_ms_csr,
  input  logic [`CSR_AW-1:0] i_ws_csr,
  // writeback ports
  input  logic               i_wb_gpr_wen,
  input  logic [`GPR_AW-1:0] i_wb_gpr_addr,
  input  logic [`XLEN-1:0]   i_wb_gpr_data,
  input  logic               i_wb_csr_wen,
  input  logic [`CSR_AW-1:0] i_wb_csr_addr,
  input  logic [`XLEN-1:0]   i_wb_csr_data
);

  logic               ds_valid, stall, br_hit, trap;
  logic [`INST_W-1:0] ds_inst;
  logic [`GPR_AW-1:0] rs1, rs2;
  logic               rs1_used, rs2_used, is_csr, ecall, mret;
  br_func_e           br_func;
  logic [`XLEN-1:0]   mtvec, mepc;
  logic [`GPR_AW-1:0] hz_gpr [3];
  logic [`CSR_AW-1:0] hz_csr [3];

  assign o_ds_allowin     = !ds_valid || (!stall && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && !stall;
  assign o_br_taken       = o_ds_to_es_valid && br_hit;
  assign trap             = o_ds_to_es_valid && i_es_allowin && ecall; // ecall handoff

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n)
      ds_valid <= 1'b0;
    else if (o_ds_allowin)
      ds_valid <= i_fs_valid;
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      ds_inst <= i_fs_inst;
      o_es_pc <= i_fs_pc;
    end
  end

  assign hz_gpr = '{i_es_rd, i_ms_rd, i_ws_rd};
  assign hz_csr = '{i_es_csr, i_ms_csr, i_ws_csr};

  always_comb begin
    stall = 1'b0;
    for (int i = 0; i < 3; i++) begin
      if (hz_gpr[i] != '0 &&
          ((rs1_used && hz_gpr[i] == rs1) || (rs2_used && hz_gpr[i] == rs2)))
        stall = 1'b1;
      if (is_csr && hz_csr[i] != '0 && hz_csr[i] == o_es_csr_addr)
        stall = 1'b1;
    end
  end

  inst_decoder u_dec (
    .i_inst       (ds_inst),
    .o_rs1        (rs1),
    .o_rs2        (rs2),
    .o_rd         (o_es_rd),
    .o_rs1_used   (rs1_used),
    .o_rs2_used   (rs2_used),
    .o_imm        (o_es_imm),
    .o_csr        (o_es_csr_addr),
    .o_alu_op     (o_es_alu_op),
    .o_src1_sel   (o_es_src1_sel),
    .o_src2_sel   (o_es_src2_sel),
    .o_word_op    (o_es_word_op),
    .o_br_func    (br_func),
    .o_gpr_wen    (o_es_gpr_wen),
    .o_csr_wen    (o_es_csr_wen),
    .o_mem_ren    (o_es_mem_ren),
    .o_mem_wen    (o_es_mem_wen),
    .o_mem_op     (o_es_mem_op),
    .o_csr_op     (o_es_csr_op),
    .o_csr_to_gpr (o_es_csr_to_gpr),
    .o_is_csr     (is_csr),
    .o_ecall      (ecall),
    .o_ebreak     (o_es_ebreak),
    .o_mret       (mret),
    .o_illegal    (o_es_illegal)
  );

  gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (o_es_rs1_data),
    .o_rdata2 (o_es_rs2_data),
    .i_wen    (i_wb_gpr_wen),
    .i_waddr  (i_wb_gpr_addr),
    .i_wdata  (i_wb_gpr_data)
  );

  csr_file u_csr (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_raddr   (o_es_csr_addr),
    .o_rdata   (o_es_csr_data),
    .i_wen     (i_wb_csr_wen),
    .i_waddr   (i_wb_csr_addr),
    .i_wdata   (i_wb_csr_data),
    .i_trap    (trap),
    .i_trap_pc (o_es_pc),
    .o_mtvec   (mtvec),
    .o_mepc    (mepc)
  );

  branch_unit u_bru (
    .i_br_func  (br_func),
    .i_rs1_data (o_es_rs1_data),
    .i_rs2_data (o_es_rs2_data),
    .i_pc       (o_es_pc),
    .i_imm      (o_es_imm),
    .i_ecall    (ecall),
    .i_mret     (mret),
    .i_mtvec    (mtvec),
    .i_mepc     (mepc),
    .o_taken    (br_hit),
    .o_target   (o_br_target)
  );

endmodule

`default_nettype wire

// File: tests/id_stage_chk.sv
// bound into id_stage; only the ms/es/ws gpr compares are checked here, csr hazards are not
`default_nettype none
`include "rv_defs.svh"

module id_stage_chk (
  input wire logic               i_clk,
  input wire logic               i_rst_n,
  input wire logic               i_fs_valid,
  input wire logic               o_ds_allowin,
  input wire logic               o_ds_to_es_valid,
  input wire logic               o_br_taken,
  input wire logic               i_es_allowin,
  input wire logic [`GPR_AW-1:0] rs1,
  input wire logic [`GPR_AW-1:0] rs2,
  input wire logic               rs1_used,
  input wire logic               rs2_used,
  input wire logic [`GPR_AW-1:0] i_es_rd,
  input wire logic [`GPR_AW-1:0] i_ms_rd,
  input wire logic [`GPR_AW-1:0] i_ws_rd,
  input wire logic [`XLEN-1:0]   o_es_imm,
  input wire logic [`XLEN-1:0]   o_es_pc,
  input wire logic [`GPR_AW-1:0] o_es_rd
);

  int   fail_count = 0;
  logic occ; // stage holds an instruction, tracked from the handshakes

  function automatic logic hits(input logic [`GPR_AW-1:0] d);
    return (d != '0) && ((rs1_used && d == rs1) || (rs2_used && d == rs2));
  endfunction

  logic hz_hit;
  assign hz_hit = hits(i_es_rd) || hits(i_ms_rd) || hits(i_ws_rd);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n)
      occ <= 1'b0;
    else if (i_fs_valid && o_ds_allowin)
      occ <= 1'b1;
    else if (o_ds_to_es_valid && i_es_allowin)
      occ <= 1'b0;
  end

  a_empty_allowin: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !occ |-> o_ds_allowin)
    else begin
      $error("empty stage with allowin low");
      fail_count++;
    end

  a_taken_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_br_taken |-> (occ && o_ds_to_es_valid))
    else begin
      $error("redirect without valid handoff");
      fail_count++;
    end

  a_hazard_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (occ && hz_hit) |-> !o_ds_to_es_valid)
    else begin
      $error("valid raised on a hazard");
      fail_count++;
    end

  a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_ds_to_es_valid && !i_es_allowin) |=>
      ($stable(o_es_imm) && $stable(o_es_pc) && $stable(o_es_rd)))
    else begin
      $error("outputs moved under back-pressure");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: tests/id_stage_tb.sv
// plays fetch, execute and writeback; only x1..x15 and mtvec are preloaded, others stay unknown
`default_nettype none
`include "rv_defs.svh"

module id_stage_tb import rv_isa_pkg::*, rv_ctrl_pkg::*; ();

  typedef struct {
    logic [31:0] inst;
    logic [63:0] pc;
    logic [4:0]  hz_rd;
    logic [11:0] hz_csr;
    logic        allowin;
    logic        stall;
    logic [4:0]  rd;
    logic [63:0] imm;
    alu_op_e     alu;
    logic [4:0]  ctl; // word, gpr_wen, mem_ren, mem_wen, illegal
    logic        taken;
    logic [63:0] target;
    logic [63:0] csr;
    src1_sel_e   s1;
    src2_sel_e   s2;
    mem_op_e     mop;
    csr_op_e     cop;
    logic [11:0] caddr;
    logic [2:0]  sys; // csr_wen, csr_to_gpr, ebreak
  } row_t;

  logic i_clk, i_rst_n, i_fs_valid, i_es_allowin;
  logic [31:0] i_fs_inst;
  logic [63:0] i_fs_pc, i_wb_gpr_data, i_wb_csr_data;
  logic [4:0] i_es_rd, i_ms_rd, i_ws_rd, i_wb_gpr_addr;
  logic [11:0] i_es_csr, i_ms_csr, i_ws_csr, i_wb_csr_addr;
  logic i_wb_gpr_wen, i_wb_csr_wen;
  logic o_ds_allowin, o_ds_to_es_valid, o_br_taken;
  logic o_es_word_op, o_es_gpr_wen, o_es_csr_wen, o_es_mem_ren, o_es_mem_wen;
  logic o_es_csr_to_gpr, o_es_ebreak, o_es_illegal;
  logic [63:0] o_es_rs1_data, o_es_rs2_data, o_es_csr_data, o_es_imm, o_es_pc, o_br_target;
  logic [4:0] o_es_rd;
  logic [11:0] o_es_csr_addr;
  alu_op_e o_es_alu_op;
  src1_sel_e o_es_src1_sel;
  src2_sel_e o_es_src2_sel;
  mem_op_e o_es_mem_op;
  csr_op_e o_es_csr_op;

  row_t rows[$];
  logic [63:0] model [0:31];
  logic [31:0] lfsr_st = 32'hc51;
  int errors = 0;
  int n_rows = 0;

  id_stage UUT (.*);

  bind id_stage id_stage_chk u_chk (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_fs_valid(i_fs_valid), .o_ds_allowin(o_ds_allowin),
    .o_ds_to_es_valid(o_ds_to_es_valid), .o_br_taken(o_br_taken),
    .i_es_allowin(i_es_allowin), .rs1(rs1), .rs2(rs2), .rs1_used(rs1_used),
    .rs2_used(rs2_used), .i_es_rd(i_es_rd), .i_ms_rd(i_ms_rd), .i_ws_rd(i_ws_rd),
    .o_es_imm(o_es_imm), .o_es_pc(o_es_pc), .o_es_rd(o_es_rd)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand64();
    logic [63:0] v;
    for (int b = 0; b < 64; b++) begin
      lfsr_st = lfsr_next(lfsr_st);
      v[b] = lfsr_st[0];
    end
    return v;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  // branch rules on the model values
  function automatic logic br_rule(input logic [2:0] f3, input logic [63:0] a,
      input logic [63:0] b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic add(input logic [31:0] inst, input logic [63:0] pc, input logic [4:0] rd,
      input logic [63:0] imm, input alu_op_e alu, input logic [4:0] ctl, input logic taken,
      input logic [63:0] target);
    row_t r;
    r = '{inst, pc, 5'd0, 12'd0, 1'b1, 1'b0, rd, imm, alu, ctl, taken, target, 64'd0,
          SRC1_REG, SRC2_REG, MEM_B, CSR_NONE, 12'd0, 3'd0};
    rows.push_back(r);
  endtask

  task automatic set_hz(input logic [4:0] hrd, input logic [11:0] hcsr, input logic alw,
      input logic stl, input logic [63:0] csr);
    row_t r;
    r = rows.pop_back();
    r.hz_rd = hrd;
    r.hz_csr = hcsr;
    r.allowin = alw;
    r.stall = stl;
    r.csr = csr;
    rows.push_back(r);
  endtask

  task automatic set_sel(input src1_sel_e s1, input src2_sel_e s2, input mem_op_e mop);
    row_t r;
    r = rows.pop_back();
    r.s1 = s1;
    r.s2 = s2;
    r.mop = mop;
    rows.push_back(r);
  endtask

  task automatic set_sys(input csr_op_e cop, input logic [11:0] caddr, input logic [2:0] sys);
    row_t r;
    r = rows.pop_back();
    r.cop = cop;
    r.caddr = caddr;
    r.sys = sys;
    rows.push_back(r);
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s exp=%h got=%h", $time, name, exp, act);
    end
  endtask

  task automatic build_rows();
    logic [63:0] pc, mtv;
    logic [2:0] f3s [6];
    pc = 64'h1000;
    mtv = 64'h8000_0100;
    f3s = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    add({20'h12345, 5'd5, OPC_LUI}, pc, 5, 64'h12345000, ALU_COPY, 5'b01000, 0, 0);
    set_sel(SRC1_REG, SRC2_IMM, MEM_B);
    add({20'hfffff, 5'd6, OPC_AUIPC}, pc + 4, 6, 64'hffff_ffff_ffff_f000, ALU_ADD,
        5'b01000, 0, 0);
    set_sel(SRC1_PC, SRC2_IMM, MEM_B);
    add(enc_i(12'hffb, 1, 0, 7, OPC_IMM), pc + 8, 7, -64'sd5, ALU_ADD, 5'b01000, 0, 0);
    set_sel(SRC1_REG, SRC2_IMM, MEM_B);
    add(enc_i(12'h421, 2, 3'b101, 7, OPC_IMM), pc, 7, 64'h421, ALU_SRA, 5'b01000, 0, 0);
    set_sel(SRC1_REG, SRC2_IMM, MEM_B);
    add(enc_r(0, 4, 3, 0, 8, OPC_OP_W), pc, 8, 0, ALU_ADD, 5'b11000, 0, 0);
    add(enc_r(7'h20, 2, 1, 0, 9, OPC_OP), pc, 9, 0, ALU_SUB, 5'b01000, 0, 0);
    add(enc_i(12'd16, 3, F3_D, 10, OPC_LOAD), pc, 10, 16, ALU_ADD, 5'b01100, 0, 0);
    set_sel(SRC1_REG, SRC2_IMM, MEM_D);
    add({7'h7f, 5'd4, 5'd5, F3_W, 5'b11000, OPC_STORE}, pc, 24, -64'sd8, ALU_ADD,
        5'b00010, 0, 0);
    set_sel(SRC1_REG, SRC2_IMM, MEM_W);
    for (int k = 0; k < 6; k++) begin
      // both operand orders give taken and not-taken cases
      add(enc_b(13'd16, 2, 1, f3s[k]), pc, 16, 16, ALU_ADD, 0,
          br_rule(f3s[k], model[1], model[2]), pc + 16);
      add(enc_b(13'h1fe0, 1, 2, f3s[k]), pc, 1, -64'sd32, ALU_ADD, 0,
          br_rule(f3s[k], model[2], model[1]), pc - 32);
    end
    add(enc_b(13'd16, 1, 1, F3_BEQ), pc, 16, 16, ALU_ADD, 0, 1, pc + 16);
    add(enc_b(13'd16, 1, 1, F3_BNE), pc, 16, 16, ALU_ADD, 0, 0, pc + 16);
    add({1'b0, 10'd0, 1'b1, 8'd0, 5'd1, OPC_JAL}, pc, 1, 2048, ALU_ADD, 5'b01000, 1,
        pc + 2048);
    set_sel(SRC1_PC, SRC2_FOUR, MEM_B);
    add(enc_i(12'd12, 6, 0, 1, OPC_JALR), pc, 1, 12, ALU_ADD, 5'b01000, 1,
        (model[6] + 64'd12) & ~64'd1);
    set_sel(SRC1_PC, SRC2_FOUR, MEM_B);
    add(32'hffff_ffff, pc, 31, 0, ALU_ADD, 5'b00001, 0, 0);
    add(enc_r(0, 2, 1, 0, 3, OPC_OP), pc, 3, 0, ALU_ADD, 5'b01000, 0, 0);
    set_hz(2, 0, 1, 1, 0);
    add(enc_i(12'd5, 1, 0, 4, OPC_IMM), pc, 4, 5, ALU_ADD, 5'b01000, 0, 0);
    set_hz(5, 0, 1, 0, 0); // rs2 field unused
    set_sel(SRC1_REG, SRC2_IMM, MEM_B);
    add(32'h0010_0073, pc, 0, 0, ALU_ADD, 0, 0, 0);
    set_hz(10, 0, 1, 1, 0);
    set_sys(CSR_NONE, 0, 3'b001);
    add(enc_r(0, 13, 12, 0, 11, OPC_OP), pc, 11, 0, ALU_ADD, 5'b01000, 0, 0);
    set_hz(0, 0, 0, 0, 0);
    add(enc_i(`CSR_MTVEC, 0, F3_CSRRS, 5, OPC_SYSTEM), pc, 5, 0, ALU_ADD, 5'b01000, 0, 0);
    set_hz(0, `CSR_MTVEC, 1, 1, mtv);
    set_sys(CSR_S, `CSR_MTVEC, 3'b010);
    add(32'h0000_0073, 64'h400, 0, 0, ALU_ADD, 0, 1, mtv);
    add(enc_i(`CSR_MEPC, 0, F3_CSRRS, 6, OPC_SYSTEM), pc, 6, 0, ALU_ADD, 5'b01000, 0, 0);
    set_hz(0, 0, 1, 0, 64'h400);
    set_sys(CSR_S, `CSR_MEPC, 3'b010);
    add(enc_i(`CSR_MCAUSE, 0, F3_CSRRS, 7, OPC_SYSTEM), pc, 7, 0, ALU_ADD, 5'b01000, 0, 0);
    set_hz(0, 0, 1, 0, `CAUSE_ECALL_M);
    set_sys(CSR_S, `CSR_MCAUSE, 3'b010);
    add(32'h3020_0073, pc, 0, 0, ALU_ADD, 0, 1, 64'h400);
    n_rows = rows.size();
  endtask

  initial begin
    wait (n_rows > 0);
    #((n_rows * 8 + 40) * 40);
    $display("timeout: the stage never handed an instruction to execute");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    row_t r;
    logic [63:0] v, h_imm, h_pc;
    logic [4:0] ra;
    i_rst_n <= 1'b0;
    i_fs_valid <= 1'b0;
    i_fs_inst <= '0;
    i_fs_pc <= '0;
    i_es_allowin <= 1'b1;
    {i_es_rd, i_ms_rd, i_ws_rd, i_es_csr, i_ms_csr, i_ws_csr} <= '0;
    {i_wb_gpr_wen, i_wb_gpr_addr, i_wb_gpr_data} <= '0;
    {i_wb_csr_wen, i_wb_csr_addr, i_wb_csr_data} <= '0;
    model[0] = '0;
    repeat (5) @(posedge i_clk);
    i_rst_n <= 1'b1;
    for (int i = 1; i < 16; i++) begin
      v = rand64();
      @(posedge i_clk);
      i_wb_gpr_wen <= 1'b1;
      i_wb_gpr_addr <= 5'(i);
      i_wb_gpr_data <= v;
      model[i] = v;
    end
    @(posedge i_clk);
    i_wb_gpr_wen <= 1'b0;
    i_wb_csr_wen <= 1'b1;
    i_wb_csr_addr <= `CSR_MTVEC;
    i_wb_csr_data <= 64'h8000_0100;
    @(posedge i_clk);
    i_wb_csr_wen <= 1'b0;
    build_rows();
    foreach (rows[n]) begin
      r = rows[n];
      @(posedge i_clk);
      i_fs_valid <= 1'b1;
      i_fs_inst <= r.inst;
      i_fs_pc <= r.pc;
      i_ms_rd <= r.hz_rd;
      i_ms_csr <= r.hz_csr;
      i_es_allowin <= r.allowin;
      @(posedge i_clk);
      i_fs_valid <= 1'b0;
      @(negedge i_clk);
      check("o_ds_to_es_valid", !r.stall, o_ds_to_es_valid);
      check("o_ds_allowin", !r.stall && r.allowin, o_ds_allowin);
      check("o_es_rd", r.rd, o_es_rd);
      check("o_es_imm", r.imm, o_es_imm);
      check("o_es_pc", r.pc, o_es_pc);
      check("o_es_alu_op", r.alu, o_es_alu_op);
      check("o_es_word_op", r.ctl[4], o_es_word_op);
      check("o_es_gpr_wen", r.ctl[3], o_es_gpr_wen);
      check("o_es_mem_ren", r.ctl[2], o_es_mem_ren);
      check("o_es_mem_wen", r.ctl[1], o_es_mem_wen);
      check("o_es_illegal", r.ctl[0], o_es_illegal);
      check("o_es_src1_sel", r.s1, o_es_src1_sel);
      check("o_es_src2_sel", r.s2, o_es_src2_sel);
      if (r.ctl[2] || r.ctl[1])
        check("o_es_mem_op", r.mop, o_es_mem_op);
      check("o_es_csr_addr", r.caddr, o_es_csr_addr);
      check("o_es_csr_op", r.cop, o_es_csr_op);
      check("o_es_csr_wen", r.sys[2], o_es_csr_wen);
      check("o_es_csr_to_gpr", r.sys[1], o_es_csr_to_gpr);
      check("o_es_ebreak", r.sys[0], o_es_ebreak);
      check("o_br_taken", r.taken && !r.stall, o_br_taken);
      if (r.taken && !r.stall)
        check("o_br_target", r.target, o_br_target);
      ra = (r.inst == 32'h0010_0073) ? 5'd10 : r.inst[19:15];
      if (ra < 16)
        check("o_es_rs1_data", model[ra], o_es_rs1_data);
      if (r.inst[24:20] < 16)
        check("o_es_rs2_data", model[r.inst[24:20]], o_es_rs2_data);
      if (r.inst[6:0] == OPC_SYSTEM && r.inst[13:12] != 2'b00)
        check("o_es_csr_data", r.csr, o_es_csr_data);
      if (r.stall || !r.allowin) begin
        h_imm = o_es_imm;
        h_pc = o_es_pc;
        @(negedge i_clk);
        check("o_ds_allowin", 0, o_ds_allowin);
        check("o_es_imm", h_imm, o_es_imm);
        check("o_es_pc", h_pc, o_es_pc);
        @(posedge i_clk);
        i_ms_rd <= '0;
        i_ms_csr <= '0;
        i_es_allowin <= 1'b1;
        @(negedge i_clk);
        while (!o_ds_to_es_valid)
          @(negedge i_clk);
      end
    end
    @(posedge i_clk);
    @(negedge i_clk);
    $display("errors: %0d over %0d rows, assertion failures: %0d", errors, n_rows,
             UUT.u_chk.fail_count);
    if (errors == 0 && UUT.u_chk.fail_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/rv_ctrl_pkg.sv
hdl/inst_decoder.sv
hdl/gpr_file.sv
hdl/csr_file.sv
hdl/branch_unit.sv
hdl/id_stage.sv
tests/id_stage_chk.sv
tests/id_stage_tb.sv
